// ==== tb.f ====
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_regs.sv
hdl/dma_seq.sv
hdl/dma_burst_ctr.sv
hdl/dma_addr_gen.sv
hdl/dma_data_buf.sv
hdl/dma_top.sv
tests/dma_models.sv
tests/dma_assert.sv
tests/dma_tb.sv

// ==== tests/dma_tb.sv ====
// ======================================================================
// DMA engine testbench with register driver, address reference model,
// transfer monitor and the test sequence
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_consts.svh"

module dma_tb
    import dma_pkg::*;
();

    logic                   clk;
    logic                   rst_n;
    logic [`DMA_PORT_N-1:0] port_wr;
    logic [7:0]             zdata;
    dram_req_t              dram;
    logic [15:0]            dram_rddata;
    logic                   dram_next;
    dev_req_t               sd;
    logic [7:0]             sd_rddata;
    logic                   sd_stb;
    dev_req_t               ide;
    logic [15:0]            ide_rddata;
    logic                   ide_stb;
    logic                   active;
    logic                   zwt;

    // current transfer as the monitor sees it
    string                  test_name;
    dma_ctrl_t              cfg;
    logic [`DMA_ADDR_W-1:0] src_start;
    logic [`DMA_ADDR_W-1:0] dst_start;
    logic [7:0]             cfg_len;
    int                     src_n;      // DRAM reads seen
    int                     dst_n;      // destination strobes seen

    dma_top UUT (
        .clk(clk), .rst_n(rst_n), .port_wr(port_wr), .zdata(zdata),
        .dram(dram), .dram_rddata(dram_rddata), .dram_next(dram_next),
        .sd(sd), .sd_rddata(sd_rddata), .sd_stb(sd_stb),
        .ide(ide), .ide_rddata(ide_rddata), .ide_stb(ide_stb),
        .active(active), .zwt(zwt)
    );

    dma_models models (
        .clk(clk), .rst_n(rst_n),
        .dram(dram), .dram_rddata(dram_rddata), .dram_next(dram_next),
        .sd(sd), .sd_rddata(sd_rddata), .sd_stb(sd_stb),
        .ide(ide), .ide_rddata(ide_rddata), .ide_stb(ide_stb)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] fill_word(input logic [`DMA_ADDR_W-1:0] a);
        return a[15:0] ^ {a[20:16], 11'h4d3};
    endfunction

    function automatic logic [7:0] sd_byte(input int j);
        return 8'(j * 29 + 7);
    endfunction

    function automatic logic [15:0] ide_word(input int j);
        return 16'(j * 945 + 7181);
    endfunction

    function automatic dma_ctrl_t make_mode(input logic wnr, input logic zw, input logic salgn,
                                            input logic dalgn, input logic asz,
                                            input logic [2:0] dev);
        dma_ctrl_t m;
        m.wnr    = wnr;
        m.zwt    = zw;
        m.salgn  = salgn;
        m.dalgn  = dalgn;
        m.asz    = asz;
        m.device = dev;
        return m;
    endfunction

    // address of word k under linear or aligned stepping
    function automatic logic [`DMA_ADDR_W-1:0] ref_addr(input logic [`DMA_ADDR_W-1:0] start,
                                                        input logic align, input int k);
        int                     b;
        int                     i;
        logic [`DMA_ADDR_W-1:0] line;
        logic [7:0]             low;
        b = k / (cfg_len + 1);
        i = k % (cfg_len + 1);
        if (!align)
            return start + k;
        if (cfg.asz)
            line = {start[`DMA_ADDR_W-1:8], 8'h00} + (b << 8);
        else
            line = {start[`DMA_ADDR_W-1:7], 7'h00} + (b << 7);
        low = (cfg.asz ? start[7:0] : {line[7], start[6:0]}) + 8'(i);  // no carry out
        return {line[`DMA_ADDR_W-1:8], low};
    endfunction

    // word k as it should arrive at the destination
    function automatic logic [15:0] ref_word(input int k);
        if (cfg.wnr || cfg.device == `DMA_DEV_RAM)
            return fill_word(ref_addr(src_start, cfg.salgn, k));
        if (cfg.device == `DMA_DEV_SD)
            return {sd_byte(2 * k), sd_byte(2 * k + 1)};   // first byte is msb
        return ide_word(k);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
            abort_run($sformatf("[ERROR] %s, %s: expected 0x%0h, actual 0x%0h",
                                test_name, what, exp, act));
    endtask

    // every accepted access is compared as it happens
    always @(posedge clk)
    begin
        logic [15:0] exp_w;
        if (UUT.u_seq.seq_chk.fail_n != 0)
            abort_run("a sequencer assertion failed");
        if (dram.req && dram_next && dram.rnw)
        begin
            check_val("source address", ref_addr(src_start, cfg.salgn, src_n), dram.addr);
            src_n++;
        end
        if (dram.req && dram_next && !dram.rnw)
        begin
            check_val("destination address", ref_addr(dst_start, cfg.dalgn, dst_n), dram.addr);
            check_val("destination word", ref_word(dst_n), dram.wrdata);
            dst_n++;
        end
        if (sd.req && sd_stb && !sd.rnw)
        begin
            exp_w = ref_word(dst_n / 2);
            check_val("SD byte", (dst_n % 2) ? exp_w[15:8] : exp_w[7:0], sd.wrdata[7:0]);
            dst_n++;
        end
        if (ide.req && ide_stb && !ide.rnw)
        begin
            check_val("IDE word", ref_word(dst_n), ide.wrdata);
            dst_n++;
        end
    end

    task automatic write_reg(input int idx, input logic [7:0] val);
        logic [`DMA_PORT_N-1:0] sel;
        sel      = '0;
        sel[idx] = 1'b1;
        @(posedge clk);
        port_wr <= sel;
        zdata   <= val;
        @(posedge clk);
        port_wr <= '0;
    endtask

    task automatic load_addr(input int base, input logic [`DMA_ADDR_W-1:0] a);
        write_reg(base, {a[6:0], 1'b0});
        write_reg(base + 1, {2'b00, a[12:7]});
        write_reg(base + 2, a[20:13]);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst_n   <= 1'b0;
        port_wr <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("active after reset", 0, active);
        check_val("DRAM request after reset", 0, dram.req);
        check_val("SD request after reset", 0, sd.req);
        check_val("IDE request after reset", 0, ide.req);
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (!active)
        begin
            @(posedge clk);
            n++;
            if (n > 4)
                abort_run("the engine did not start after launch");
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (active)
        begin
            @(posedge clk);
            n++;
            if (n > limit)
                abort_run("timeout while waiting for the transfer to finish");
        end
    endtask

    // port writes while running must not reach the registers
    task automatic poke_while_busy();
        write_reg(`DMA_LEN, 8'hff);
        write_reg(`DMA_NUM, 8'h07);
        write_reg(`DMA_SADDRL, 8'h00);
        write_reg(`DMA_DADDRX, 8'h05);
        write_reg(`DMA_LAUNCH, 8'h00);
        check_val("active during port writes", 1, active);
    endtask

    task automatic run_xfer(input string name, input dma_ctrl_t mode,
                            input logic [`DMA_ADDR_W-1:0] src, input logic [`DMA_ADDR_W-1:0] dst,
                            input logic [7:0] len, input logic [7:0] num, input logic poke);
        int   total;
        logic src_ram;
        test_name = name;
        cfg       = mode;
        src_start = src;
        dst_start = dst;
        cfg_len   = len;
        total     = (len + 1) * (num + 1);
        src_ram   = mode.wnr || mode.device == `DMA_DEV_RAM;
        reset_dut();
        load_addr(`DMA_SADDRL, src);
        load_addr(`DMA_DADDRL, dst);
        write_reg(`DMA_LEN, len);
        write_reg(`DMA_NUM, num);
        src_n = 0;
        dst_n = 0;
        write_reg(`DMA_LAUNCH, mode);
        wait_busy();
        if (poke)
            poke_while_busy();
        wait_idle(20000);
        check_val("DRAM read count", src_ram ? total : 0, src_n);
        check_val("destination strobe count",
                  (mode.wnr && mode.device == `DMA_DEV_SD) ? 2 * total : total, dst_n);
        check_val("zwt flag", mode.zwt, zwt);
    endtask

    initial
    begin
        logic [`DMA_ADDR_W:0] a;
        rst_n     = 1'b0;
        port_wr   = '0;
        zdata     = 8'h00;
        test_name = "setup";
        for (a = 0; a < (1 << `DMA_ADDR_W); a++)
            models.mem[a[`DMA_ADDR_W-1:0]] = fill_word(a[`DMA_ADDR_W-1:0]);
        for (int j = 0; j < 512; j++)
            models.sd_src[j] = sd_byte(j);
        for (int j = 0; j < 256; j++)
            models.ide_src[j] = ide_word(j);

        run_xfer("linear RAM copy", make_mode(0, 1, 0, 0, 0, `DMA_DEV_RAM),
                 21'h0011fd, 21'h1f00fd, 8'd3, 8'd1, 1'b1);
        run_xfer("aligned copy 128", make_mode(0, 0, 1, 1, 0, `DMA_DEV_RAM),
                 21'h0030c5, 21'h0150a0, 8'd4, 8'd2, 1'b0);
        run_xfer("aligned copy 256", make_mode(0, 0, 1, 1, 1, `DMA_DEV_RAM),
                 21'h0050f0, 21'h1200fe, 8'd2, 8'd3, 1'b0);
        run_xfer("SD to RAM", make_mode(0, 0, 0, 0, 0, `DMA_DEV_SD),
                 21'h000000, 21'h002000, 8'd3, 8'd0, 1'b0);
        run_xfer("RAM to SD", make_mode(1, 0, 0, 0, 0, `DMA_DEV_SD),
                 21'h000300, 21'h000000, 8'd2, 8'd1, 1'b0);
        run_xfer("IDE to RAM", make_mode(0, 0, 0, 1, 0, `DMA_DEV_IDE),
                 21'h000000, 21'h002410, 8'd3, 8'd1, 1'b0);
        run_xfer("RAM to IDE", make_mode(1, 1, 0, 0, 0, `DMA_DEV_IDE),
                 21'h000400, 21'h000000, 8'd4, 8'd0, 1'b0);

        if (UUT.u_seq.seq_chk.fail_n != 0)
            abort_run("sequencer assertions failed during the run");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/dma_assert.sv ====
// ======================================================================
// DMA sequencer assertions and their bind into dma_seq
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module dma_assert (
    input wire clk,
    input wire rst_n,
    input wire active,
    input wire phase,
    input wire bsel,
    input wire mem_req,
    input wire dev_req,
    input wire dram_next,
    input wire sd_stb,
    input wire ide_stb
);

    int fail_n = 0;     // assertion failures so far

    // a strobe only ever meets the one target that holds the request
    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req && (dev_req || sd_stb || ide_stb)) && !(dev_req && dram_next))
    else
    begin
        $error("memory and device requested in the same cycle");
        fail_n++;
    end

    // held request with no strobe keeps its phase
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !dram_next |=> mem_req && $stable(phase))
    else
    begin
        $error("memory request dropped or changed before its strobe");
        fail_n++;
    end

    a_dev_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dev_req && !sd_stb && !ide_stb |=> dev_req && $stable(phase) && $stable(bsel))
    else
    begin
        $error("device request dropped or changed before its strobe");
        fail_n++;
    end

    // idle engine requests nothing and rests in the read phase
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> !mem_req && !dev_req && !phase && !bsel)
    else
    begin
        $error("request raised while the engine is idle");
        fail_n++;
    end

endmodule

bind dma_seq dma_assert seq_chk (
    .clk(clk),
    .rst_n(rst_n),
    .active(active),
    .phase(phase),
    .bsel(bsel),
    .mem_req(mem_req),
    .dev_req(dev_req),
    .dram_next(dram_next),
    .sd_stb(sd_stb),
    .ide_stb(ide_stb)
);

`default_nettype wire

// ==== tests/dma_models.sv ====
// ======================================================================
// DRAM, SD and IDE models for the DMA testbench, random strobe delay
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_consts.svh"

module dma_models
    import dma_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  dram_req_t   dram,
    output logic [15:0] dram_rddata,
    output logic        dram_next,
    input  dev_req_t    sd,
    output logic [7:0]  sd_rddata,
    output logic        sd_stb,
    input  dev_req_t    ide,
    output logic [15:0] ide_rddata,
    output logic        ide_stb
);

    logic [15:0] mem [0:(1 << `DMA_ADDR_W) - 1];
    logic [7:0]  sd_src [0:511];    // SD read stream
    logic [15:0] ide_src [0:255];   // IDE read stream
    logic [8:0]  sd_rd_n;
    logic [7:0]  ide_rd_n;
    logic [31:0] rng;
    logic [1:0]  gap;               // idle cycles before the next strobe

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial
    begin
        rng         = 32'd84;
        dram_next   = 1'b0;
        sd_stb      = 1'b0;
        ide_stb     = 1'b0;
        dram_rddata = 16'h0000;
        sd_rddata   = 8'h00;
        ide_rddata  = 16'h0000;
    end

    // one target at a time, each strobe lasts a single cycle
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            dram_next <= 1'b0;
            sd_stb    <= 1'b0;
            ide_stb   <= 1'b0;
            sd_rd_n   = '0;
            ide_rd_n  = '0;
            gap       = 2'd0;
        end
        else if (dram_next || sd_stb || ide_stb)
        begin
            dram_next <= 1'b0;
            sd_stb    <= 1'b0;
            ide_stb   <= 1'b0;
        end
        else if (dram.req || sd.req || ide.req)
        begin
            if (gap != 2'd0)
                gap = gap - 2'd1;
            else
            begin
                rng = lcg_next(rng);
                gap = rng[17:16];
                if (dram.req)
                begin
                    dram_next <= 1'b1;
                    if (dram.rnw)
                        dram_rddata <= mem[dram.addr];
                    else
                        mem[dram.addr] <= dram.wrdata;
                end
                else if (sd.req)
                begin
                    sd_stb <= 1'b1;
                    if (sd.rnw)
                    begin
                        sd_rddata <= sd_src[sd_rd_n];
                        sd_rd_n = sd_rd_n + 9'd1;
                    end
                end
                else
                begin
                    ide_stb <= 1'b1;
                    if (ide.rnw)
                    begin
                        ide_rddata <= ide_src[ide_rd_n];
                        ide_rd_n = ide_rd_n + 8'd1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dma_top.sv ====
// ==================================================================
// DMA engine top level: registers, counters, sequencer, datapath
// ==================================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_consts.svh"

module dma_top
    import dma_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`DMA_PORT_N-1:0] port_wr,
    input  wire [7:0]             zdata,
    output dram_req_t             dram,
    input  wire [15:0]            dram_rddata,
    input  wire                   dram_next,
    output dev_req_t              sd,
    input  wire [7:0]             sd_rddata,
    input  wire                   sd_stb,
    output dev_req_t              ide,
    input  wire [15:0]            ide_rddata,
    input  wire                   ide_stb,
    output logic                  active,
    output logic                  zwt
);

    dma_ctrl_t              ctrl;
    dma_word_u              data;
    logic [7:0]             len;
    logic [7:0]             num;
    logic                   launch;
    logic [2:0]             saddr_wr;
    logic [2:0]             daddr_wr;
    logic                   next_burst;
    logic                   phase;
    logic                   bsel;
    logic                   mem_req;
    logic                   dev_req;
    logic                   sd_sel;
    logic                   ide_sel;
    logic                   cyc_end;
    logic [`DMA_ADDR_W-1:0] saddr;
    logic [`DMA_ADDR_W-1:0] daddr;
    logic                   mem_rd;
    logic                   mem_wr;
    logic                   dev_rd;

    assign mem_rd = mem_req & dram_next & ~phase;
    assign mem_wr = mem_req & dram_next & phase;
    assign dev_rd = dev_req & ~phase;

    dma_regs u_regs (
        .clk(clk), .rst_n(rst_n), .port_wr(port_wr), .zdata(zdata), .active(active),
        .ctrl(ctrl), .len(len), .num(num), .launch(launch),
        .saddr_wr(saddr_wr), .daddr_wr(daddr_wr)
    );

    dma_burst_ctr u_burst_ctr (
        .clk(clk), .rst_n(rst_n), .launch(launch), .cyc_end(cyc_end),
        .len(len), .num(num), .active(active), .next_burst(next_burst)
    );

    dma_seq u_seq (
        .clk(clk), .rst_n(rst_n), .launch(launch), .active(active), .ctrl(ctrl),
        .dram_next(dram_next), .sd_stb(sd_stb), .ide_stb(ide_stb),
        .phase(phase), .bsel(bsel), .mem_req(mem_req), .dev_req(dev_req),
        .sd_sel(sd_sel), .ide_sel(ide_sel), .cyc_end(cyc_end)
    );

    dma_addr_gen u_src_addr (
        .clk(clk), .zdata(zdata), .load(saddr_wr), .step(mem_rd),
        .align(ctrl.salgn), .asz(ctrl.asz), .next_burst(next_burst), .addr(saddr)
    );

    dma_addr_gen u_dst_addr (
        .clk(clk), .zdata(zdata), .load(daddr_wr), .step(mem_wr),
        .align(ctrl.dalgn), .asz(ctrl.asz), .next_burst(next_burst), .addr(daddr)
    );

    dma_data_buf u_data_buf (
        .clk(clk), .capture_mem(mem_rd),
        .capture_sd(dev_rd & sd_sel & sd_stb), .capture_ide(dev_rd & ide_sel & ide_stb),
        .bsel(bsel), .dram_rddata(dram_rddata), .ide_rddata(ide_rddata),
        .sd_rddata(sd_rddata), .data(data)
    );

    assign zwt = ctrl.zwt;      // stored only, engine ignores it

    always_comb
    begin
        dram.req    = mem_req;
        dram.rnw    = ~phase;
        dram.addr   = phase ? daddr : saddr;
        dram.wrdata = data.word;

        // lsb goes out first on SD
        sd.req    = dev_req & sd_sel;
        sd.rnw    = ~phase;
        sd.wrdata = {8'h00, bsel ? data.bytes.msb : data.bytes.lsb};

        ide.req    = dev_req & ide_sel;
        ide.rnw    = ~phase;
        ide.wrdata = data.word;
    end

endmodule

`default_nettype wire

// ==== hdl/dma_data_buf.sv ====
// ==================================================================
// DMA transfer buffer, word capture or SD byte assembly
// ==================================================================
`timescale 1ns/1ns
`default_nettype none

module dma_data_buf
    import dma_pkg::*;
(
    input  wire        clk,
    input  wire        capture_mem,
    input  wire        capture_sd,
    input  wire        capture_ide,
    input  wire        bsel,
    input  wire [15:0] dram_rddata,
    input  wire [15:0] ide_rddata,
    input  wire [7:0]  sd_rddata,
    output dma_word_u  data
);

    always_ff @(posedge clk)
    begin
        if (capture_mem)
            data.word <= dram_rddata;
        else if (capture_sd)
        begin
            if (bsel)
                data.bytes.lsb <= sd_rddata;    // second byte
            else
                data.bytes.msb <= sd_rddata;
        end
        else if (capture_ide)
            data.word <= ide_rddata;
    end

endmodule

`default_nettype wire

// ==== hdl/dma_addr_gen.sv ====
// ==================================================================
// DMA DRAM address register with CPU load and linear/aligned step
// ==================================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_consts.svh"

module dma_addr_gen (
    input  wire                    clk,
    input  wire [7:0]              zdata,
    input  wire [2:0]              load,        // {extra, high, low}
    input  wire                    step,
    input  wire                    align,
    input  wire                    asz,
    input  wire                    next_burst,
    output logic [`DMA_ADDR_W-1:0] addr
);

    logic [7:0]             offs;       // line offset restored per burst
    logic [8:0]             inc_l;
    logic [7:0]             next_l;
    logic [1:0]             add_h;
    logic [13:0]            next_h;
    logic                   next_m;
    logic [`DMA_ADDR_W-1:0] addr_next;

    assign inc_l  = {1'b0, addr[7:0]} + 9'd1;
    assign next_l = (align & next_burst) ? offs : inc_l[7:0];

    // upper part counts in 128 word units
    assign add_h  = align ? {next_burst & asz, next_burst & ~asz}
                          : {inc_l[8], 1'b0};
    assign next_h = addr[`DMA_ADDR_W-1:7] + {12'd0, add_h};

    // bit 7 belongs to the offset on 256 word lines, to the line otherwise
    assign next_m = align ? (asz ? next_l[7] : next_h[0]) : inc_l[7];

    assign addr_next = {next_h[13:1], next_m, next_l[6:0]};

    always_ff @(posedge clk)
    begin
        if (step)
            addr <= addr_next;
        else
        begin
            if (load[0])
            begin
                addr[6:0] <= zdata[7:1];
                offs[6:0] <= zdata[7:1];
            end
            if (load[1])
            begin
                addr[12:7] <= zdata[5:0];
                offs[7]    <= zdata[0];
            end
            if (load[2])
                addr[`DMA_ADDR_W-1:13] <= zdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dma_burst_ctr.sv ====
// ==================================================================
// DMA word-per-burst and burst-per-launch counters
// ==================================================================
`timescale 1ns/1ns
`default_nettype none

module dma_burst_ctr (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       launch,
    input  wire       cyc_end,
    input  wire [7:0] len,
    input  wire [7:0] num,
    output logic      active,
    output logic      next_burst
);

    logic [7:0] b_ctr;          // words left in burst, minus one
    logic [8:0] n_ctr;          // bursts left, top bit set when idle
    logic [8:0] b_ctr_dec;
    logic [7:0] b_ctr_next;

    assign b_ctr_dec  = {1'b0, b_ctr} - 9'd1;
    assign next_burst = b_ctr_dec[8];               // borrow on last word
    assign b_ctr_next = next_burst ? len : b_ctr_dec[7:0];

    assign active = ~n_ctr[8];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            n_ctr[8] <= 1'b1;                       // idle after reset
        else if (launch)
        begin
            b_ctr <= len;
            n_ctr <= {1'b0, num};
        end
        else if (cyc_end)
        begin
            b_ctr <= b_ctr_next;
            n_ctr <= n_ctr - {8'd0, next_burst};    // wraps to idle after last burst
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dma_seq.sv ====
// ==================================================================
// DMA cycle sequencer: read/write phase, SD byte select, requests
// ==================================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_consts.svh"

module dma_seq
    import dma_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       launch,
    input  wire       active,
    input  dma_ctrl_t ctrl,
    input  wire       dram_next,
    input  wire       sd_stb,
    input  wire       ide_stb,
    output logic      phase,        // 0 - read, 1 - write
    output logic      bsel,         // SD byte, 0 - first
    output logic      mem_req,
    output logic      dev_req,
    output logic      sd_sel,
    output logic      ide_sel,
    output logic      cyc_end
);

    logic dv_ram;
    logic dev_stb;
    logic phase_end;
    logic byte_switch;

    assign dv_ram  = ctrl.device == `DMA_DEV_RAM;
    assign sd_sel  = ctrl.device == `DMA_DEV_SD;
    assign ide_sel = ctrl.device == `DMA_DEV_IDE;

    // RAM copy uses memory in both phases,
    // otherwise wnr picks which side goes first
    assign mem_req = active & (dv_ram | (ctrl.wnr ^ phase));
    assign dev_req = active & ~dv_ram & (ctrl.wnr ^ ~phase);

    // SD word is done only on its second byte
    assign dev_stb     = (sd_sel & sd_stb & bsel) | (ide_sel & ide_stb);
    assign phase_end   = (mem_req & dram_next) | (dev_req & dev_stb);
    assign cyc_end     = phase & phase_end;
    assign byte_switch = dev_req & sd_sel & sd_stb;

    always_ff @(posedge clk)
    begin
        if (!rst_n || launch)
        begin
            phase <= 1'b0;
            bsel  <= 1'b0;
        end
        else
        begin
            if (phase_end)
                phase <= ~phase;
            if (byte_switch)
                bsel <= ~bsel;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dma_regs.sv ====
// ==================================================================
// DMA register file: port strobe decode, control, length and count
// ==================================================================
`timescale 1ns/1ns
`default_nettype none

`include "dma_consts.svh"

module dma_regs
    import dma_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`DMA_PORT_N-1:0] port_wr,
    input  wire [7:0]             zdata,
    input  wire                   active,
    output dma_ctrl_t             ctrl,
    output logic [7:0]            len,
    output logic [7:0]            num,
    output logic                  launch,
    output logic [2:0]            saddr_wr,
    output logic [2:0]            daddr_wr
);

    logic [`DMA_PORT_N-1:0] wr;

    assign wr = port_wr & {`DMA_PORT_N{~active}};   // CPU locked out while running

    assign launch   = wr[`DMA_LAUNCH];
    assign saddr_wr = {wr[`DMA_SADDRX], wr[`DMA_SADDRH], wr[`DMA_SADDRL]};
    assign daddr_wr = {wr[`DMA_DADDRX], wr[`DMA_DADDRH], wr[`DMA_DADDRL]};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ctrl <= '0;
        else if (launch)
            ctrl <= dma_ctrl_t'(zdata);  // launch byte carries the mode
    end

    // burst geometry
    always_ff @(posedge clk)
    begin
        if (wr[`DMA_LEN])
            len <= zdata;
        if (wr[`DMA_NUM])
            num <= zdata;
    end

endmodule

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
// ==================================================================
// DMA engine types: control byte, bus request structs, data word
// ==================================================================
`default_nettype none

`include "dma_consts.svh"

package dma_pkg;

    // launch byte, msb first as written by the CPU
    typedef struct packed {
        logic       wnr;        // 1 - RAM to device
        logic       zwt;        // CPU wait flag, passed through
        logic       salgn;
        logic       dalgn;
        logic       asz;        // 1 - 256 word line, 0 - 128 word line
        logic [2:0] device;
    } dma_ctrl_t;

    typedef struct packed {
        logic [7:0] msb;
        logic [7:0] lsb;
    } dma_bytes_t;

    // byte view for SD assembly, word view for DRAM and IDE
    typedef union packed {
        logic [15:0] word;
        dma_bytes_t  bytes;
    } dma_word_u;

    typedef struct packed {
        logic                   req;
        logic                   rnw;
        logic [`DMA_ADDR_W-1:0] addr;
        logic [15:0]            wrdata;
    } dram_req_t;

    // shared by SD and IDE; SD only drives the low byte
    typedef struct packed {
        logic        req;
        logic        rnw;
        logic [15:0] wrdata;
    } dev_req_t;

endpackage

`default_nettype wire

// ==== hdl/dma_consts.svh ====
// ==================================================================
// DMA engine widths, register strobe indices and device codes
// ==================================================================
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

`define DMA_ADDR_W   21     // DRAM word address
`define DMA_PORT_N   9      // port write strobes

`define DMA_SADDRL   0
`define DMA_SADDRH   1
`define DMA_SADDRX   2
`define DMA_DADDRL   3
`define DMA_DADDRH   4
`define DMA_DADDRX   5
`define DMA_LEN      6
`define DMA_LAUNCH   7
`define DMA_NUM      8

`define DMA_DEV_RAM  3'd1
`define DMA_DEV_SD   3'd2
`define DMA_DEV_IDE  3'd3

`endif
